// File: source/uart_pkg.sv
package uart_pkg;

	// one byte as it travels on the serial line.
	typedef logic [7:0] uart_byte_t;

	// a transmit request carries a start that is a single-cycle strobe.
	typedef struct packed {
		logic       start;
		uart_byte_t data;
	} tx_cmd_t;

	// the receive report has valid high for one cycle per frame.
	typedef struct packed {
		logic       valid;
		logic       frame_error; // stop bit was sampled low.
		uart_byte_t data;
	} rx_result_t;

	// transmit FSM states.
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	// receive FSM states.
	// RX_WAIT_HIGH holds off after a framing error until the line recovers.
	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP,
		RX_WAIT_HIGH
	} rx_state_e;

endpackage

// File: source/baud_timer.sv
`timescale 1ns/1ps

module baud_timer #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic clk,
	input  logic reset_n,
	input  logic run,
	output logic tick,
	output logic half
);

	localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] MID  = CNT_W'(CLKS_PER_BIT / 2 - 1);

	logic [CNT_W-1:0] count;

	// the count restarts from zero every time run rises.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			count <= '0;
		end else if (!run) begin
			count <= '0;
		end else if (count == LAST) begin
			count <= '0; // wrap at the end of each bit.
		end else begin
			count <= count + 1'b1;
		end
	end

	// Both pulses come straight off the count register.
	// tick marks the last clock of a bit, half the middle of it.
	always_comb begin
		tick = run && (count == LAST);
		half = run && (count == MID);
	end

endmodule

// File: source/tx_sequencer.sv
`timescale 1ns/1ps

module tx_sequencer import uart_pkg::*; (
	input  logic clk,
	input  logic reset_n,
	input  logic start,
	input  logic tick,
	output logic run,
	output logic load,
	output logic shift,
	output logic busy,
	output logic done
);

	tx_state_e  state;
	tx_state_e  state_next;
	logic [2:0] bit_cnt;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= TX_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// counts data bits already on the line.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			bit_cnt <= 3'd0;
		end else if (state == TX_START) begin
			bit_cnt <= 3'd0;
		end else if ((state == TX_DATA) && tick) begin
			bit_cnt <= bit_cnt + 3'd1;
		end
	end

	always_comb begin
		state_next = state;
		load       = 1'b0;
		shift      = 1'b0;
		done       = 1'b0;
		case (state)
			TX_IDLE: begin
				if (start) begin
					load       = 1'b1; // frame register takes the byte now.
					state_next = TX_START;
				end
			end
			TX_START: begin
				if (tick) begin
					shift      = 1'b1;
					state_next = TX_DATA;
				end
			end
			TX_DATA: begin
				if (tick) begin
					shift = 1'b1;
					if (bit_cnt == 3'd7) begin
						state_next = TX_STOP;
					end
				end
			end
			TX_STOP: begin
				if (tick) begin
					shift      = 1'b1;
					done       = 1'b1; // last clock of the stop bit.
					state_next = TX_IDLE;
				end
			end
			default: state_next = TX_IDLE;
		endcase
	end

	assign run  = (state != TX_IDLE);
	assign busy = (state != TX_IDLE); // starts seen here are dropped.

endmodule

// File: source/tx_shifter.sv
`timescale 1ns/1ps

module tx_shifter import uart_pkg::*; (
	input  logic       clk,
	input  logic       reset_n,
	input  uart_byte_t data,
	input  logic       load,
	input  logic       shift,
	output logic       tx_pin
);

	// the frame holds the stop bit in bit nine and the start bit in bit zero.
	logic [9:0] frame;

	// Ones are shifted in behind the frame, so once the stop bit has gone
	// out the register is all ones again and the line rests high.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			frame <= '1;
		end else if (load) begin
			frame <= {1'b1, data, 1'b0};
		end else if (shift) begin
			frame <= {1'b1, frame[9:1]};
		end
	end

	assign tx_pin = frame[0]; // lsb first on the wire.

endmodule

// File: source/rx_sequencer.sv
`timescale 1ns/1ps

module rx_sequencer import uart_pkg::*; (
	input  logic clk,
	input  logic reset_n,
	input  logic line,
	input  logic half,
	output logic run,
	output logic sample,
	output logic result_valid,
	output logic frame_error
);

	rx_state_e  state;
	rx_state_e  state_next;
	logic [2:0] bit_cnt;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= RX_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			bit_cnt <= 3'd0;
		end else if (state == RX_START) begin
			bit_cnt <= 3'd0;
		end else if ((state == RX_DATA) && half) begin
			bit_cnt <= bit_cnt + 3'd1;
		end
	end

	always_comb begin
		state_next   = state;
		sample       = 1'b0;
		result_valid = 1'b0;
		frame_error  = 1'b0;
		case (state)
			RX_IDLE: begin
				if (!line) begin
					state_next = RX_START; // falling edge, maybe a start bit.
				end
			end
			RX_START: begin
				// A start bit must still be low at its middle.
				// Anything shorter is treated as noise.
				if (half) begin
					if (line) begin
						state_next = RX_IDLE;
					end else begin
						state_next = RX_DATA;
					end
				end
			end
			RX_DATA: begin
				if (half) begin
					sample = 1'b1;
					if (bit_cnt == 3'd7) begin
						state_next = RX_STOP;
					end
				end
			end
			RX_STOP: begin
				if (half) begin
					result_valid = 1'b1;
					frame_error  = !line;
					if (line) begin
						state_next = RX_IDLE;
					end else begin
						state_next = RX_WAIT_HIGH;
					end
				end
			end
			RX_WAIT_HIGH: begin
				if (line) begin
					state_next = RX_IDLE;
				end
			end
			default: state_next = RX_IDLE;
		endcase
	end

	// the timer only runs while a frame is being received.
	assign run = (state == RX_START) || (state == RX_DATA) || (state == RX_STOP);

endmodule

// File: source/rx_shifter.sv
`timescale 1ns/1ps

module rx_shifter import uart_pkg::*; (
	input  logic       clk,
	input  logic       reset_n,
	input  logic       rx_pin,
	input  logic       sample,
	output logic       line,
	output uart_byte_t data
);

	logic [1:0] sync;

	// two flops guard against metastability and reset to the idle level.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			sync <= 2'b11;
		end else begin
			sync <= {sync[0], rx_pin};
		end
	end

	assign line = sync[1];

	// Bits arrive lsb first, so each new one enters at the top
	// and the first one ends up in bit zero after eight samples.
	always_ff @(posedge clk) begin
		if (sample) begin
			data <= {line, data[7:1]};
		end
	end

endmodule

// File: source/uart_core.sv
`timescale 1ns/1ps

module uart_core import uart_pkg::*; #(
	parameter int CLK_HZ    = 1_000_000,
	parameter int BAUD_RATE = 125_000
) (
	input  logic       clk,
	input  logic       reset_n,
	input  tx_cmd_t    tx_cmd,
	output logic       tx_pin,
	output logic       tx_busy,
	output logic       tx_done,
	input  logic       rx_pin,
	output rx_result_t rx_result
);

	localparam int CLKS_PER_BIT = CLK_HZ / BAUD_RATE; // needs to be 4 or more.

	logic       tx_run;
	logic       tx_tick;
	logic       tx_load;
	logic       tx_shift;
	logic       rx_run;
	logic       rx_half;
	logic       rx_line;
	logic       rx_sample;
	logic       rx_valid;
	logic       rx_ferr;
	uart_byte_t rx_data;

	baud_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx_timer (
		.clk     (clk),
		.reset_n (reset_n),
		.run     (tx_run),
		.tick    (tx_tick),
		.half    ()
	);

	tx_sequencer u_tx_seq (
		.clk     (clk),
		.reset_n (reset_n),
		.start   (tx_cmd.start),
		.tick    (tx_tick),
		.run     (tx_run),
		.load    (tx_load),
		.shift   (tx_shift),
		.busy    (tx_busy),
		.done    (tx_done)
	);

	tx_shifter u_tx_shift (
		.clk     (clk),
		.reset_n (reset_n),
		.data    (tx_cmd.data),
		.load    (tx_load),
		.shift   (tx_shift),
		.tx_pin  (tx_pin)
	);

	// receive side keeps its own timer so both directions run independently.
	baud_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx_timer (
		.clk     (clk),
		.reset_n (reset_n),
		.run     (rx_run),
		.tick    (),
		.half    (rx_half)
	);

	rx_sequencer u_rx_seq (
		.clk          (clk),
		.reset_n      (reset_n),
		.line         (rx_line),
		.half         (rx_half),
		.run          (rx_run),
		.sample       (rx_sample),
		.result_valid (rx_valid),
		.frame_error  (rx_ferr)
	);

	rx_shifter u_rx_shift (
		.clk     (clk),
		.reset_n (reset_n),
		.rx_pin  (rx_pin),
		.sample  (rx_sample),
		.line    (rx_line),
		.data    (rx_data)
	);

	assign rx_result = '{valid: rx_valid, frame_error: rx_ferr, data: rx_data};

endmodule

// File: testbench/uart_core_sva.sv
`timescale 1ns/1ps

module uart_core_sva import uart_pkg::*; (
	input logic      clk,
	input logic      reset_n,
	input logic      tx_busy,
	input logic      tx_done,
	input logic      tx_pin,
	input logic      rx_valid,
	input tx_state_e tx_state
);

	int fail_count = 0;

	reset_quiet: assert property (@(posedge clk) !reset_n |-> (!tx_busy && !tx_done))
		else begin
			fail_count++;
			$error("tx_busy or tx_done high during reset");
		end

	// done closes the frame and the transmitter is free right after it.
	done_single: assert property (@(posedge clk) disable iff (!reset_n)
		tx_done |=> (!tx_done && !tx_busy))
		else begin
			fail_count++;
			$error("tx_done wider than one cycle or not followed by idle");
		end

	idle_high: assert property (@(posedge clk) disable iff (!reset_n)
		(tx_state == TX_IDLE) |-> tx_pin)
		else begin
			fail_count++;
			$error("tx_pin low while the transmitter is idle");
		end

	valid_single: assert property (@(posedge clk) disable iff (!reset_n)
		rx_valid |=> !rx_valid)
		else begin
			fail_count++;
			$error("rx_result.valid high on two cycles in a row");
		end

endmodule

bind uart_core uart_core_sva i_sva (
	.clk      (clk),
	.reset_n  (reset_n),
	.tx_busy  (tx_busy),
	.tx_done  (tx_done),
	.tx_pin   (tx_pin),
	.rx_valid (rx_result.valid),
	.tx_state (u_tx_seq.state)
);

// File: testbench/uart_core_tb.sv
`timescale 1ns/1ps

module uart_core_tb
	import uart_pkg::*;
();

	localparam int CLK_HZ         = 1_000_000;
	localparam int BAUD_RATE      = 125_000;
	localparam int CPB            = CLK_HZ / BAUD_RATE;
	localparam int TX_FRAMES      = 40;
	localparam int SER_FRAMES     = 3;
	localparam int GLITCH_CYCLES  = 2 + 11 * CPB;
	localparam int IDLE_CYCLES    = 64 + 24 * CPB;
	localparam int TIMEOUT_CYCLES = (TX_FRAMES + SER_FRAMES) * 12 * CPB
		+ GLITCH_CYCLES + IDLE_CYCLES + 400;

	logic       clk = 1'b0;
	logic       reset_n;
	tx_cmd_t    tx_cmd;
	logic       tx_pin;
	logic       tx_busy;
	logic       tx_done;
	logic       rx_pin;
	rx_result_t rx_result;

	logic       loopback;
	logic       ser_line;
	int         cyc = 0;
	int         errors = 0;
	int         checks = 0;
	int         accepted = 0;
	int         next_free = 0;
	int         done_count = 0;
	int         frames_seen = 0;
	int         rx_count = 0;
	uart_byte_t tx_exp_q[$];
	int         tx_edge_q[$];
	rx_result_t rx_exp_q[$];

	uart_core #(.CLK_HZ(CLK_HZ), .BAUD_RATE(BAUD_RATE)) i_dut (
		.clk       (clk),
		.reset_n   (reset_n),
		.tx_cmd    (tx_cmd),
		.tx_pin    (tx_pin),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.rx_pin    (rx_pin),
		.rx_result (rx_result)
	);

	assign rx_pin = loopback ? tx_pin : ser_line; // loopback or the serial line model.

	always #4 clk = ~clk;

	task automatic report_counts();
		$display("checks: %0d, errors: %0d", checks, errors);
	endtask

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYCLES) begin
			errors++;
			$display("TIMEOUT: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
			report_counts();
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic compare_level(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected 0x%02h, actual 0x%02h", name, exp, act);
		end
	endtask

	task automatic check_rx_result(input string name, input rx_result_t exp,
			input rx_result_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected data 0x%02h ferr %b, actual data 0x%02h ferr %b",
				name, exp.data, exp.frame_error, act.data, act.frame_error);
		end
	endtask

	// every stimulus task starts and ends 1 ns after a rising edge.
	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic send_strobe(input uart_byte_t b);
		int edge_no;
		edge_no = cyc + 1; // the strobe is sampled on the next edge.
		tx_cmd = '{start: 1'b1, data: b};
		// The transmitter is free again one cycle after its done cycle.
		if (edge_no >= next_free) begin
			tx_exp_q.push_back(b);
			tx_edge_q.push_back(edge_no);
			rx_exp_q.push_back('{valid: 1'b1, frame_error: 1'b0, data: b});
			next_free = edge_no + 10 * CPB + 1;
			accepted++;
		end
		wait_cycles(1);
		tx_cmd.start = 1'b0;
	endtask

	task automatic send_serial_frame(input uart_byte_t b, input logic stop_level);
		logic [9:0] bits;
		bits = {stop_level, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			ser_line = bits[i];
			wait_cycles(CPB);
		end
	endtask

	task automatic send_glitch();
		ser_line = 1'b0;
		wait_cycles(2);
		ser_line = 1'b1;
	endtask

	// samples the line at mid-bit once the transmitter has gone busy.
	initial begin : tx_monitor
		logic [9:0] seen;
		int         start_cyc;
		uart_byte_t exp_byte;
		forever begin
			@(negedge clk);
			if (reset_n && tx_busy) begin
				start_cyc = cyc;
				frames_seen++;
				if (tx_edge_q.size() == 0) begin
					errors++;
					$display("transmitter began a frame at cycle %0d without a start", cyc);
					while (tx_busy) @(negedge clk);
				end else begin
					exp_byte = tx_exp_q.pop_front();
					if (tx_edge_q.pop_front() != start_cyc) begin
						errors++;
						$display("transmit frame began at cycle %0d, not after its start edge",
							start_cyc);
					end
					repeat (CPB / 2) @(negedge clk);
					for (int j = 0; j < 10; j++) begin
						seen[j] = tx_pin;
						if (j < 9) repeat (CPB) @(negedge clk);
					end
					compare_level("tx start bit", 1'b0, seen[0]);
					compare_level("tx stop bit", 1'b1, seen[9]);
					check_byte("tx byte", exp_byte, seen[8:1]);
					// tx_done belongs to the last cycle of the stop bit.
					repeat (CPB - CPB / 2 - 1) @(negedge clk);
					compare_level("tx busy at done", 1'b1, tx_busy);
					if (!tx_done) begin
						errors++;
						$display("tx_done did not pulse at the end of the frame at cycle %0d", cyc);
					end
				end
			end
		end
	end

	always @(negedge clk) begin
		if (reset_n && tx_done) done_count++;
	end

	always @(negedge clk) begin
		if (reset_n && rx_result.valid) begin
			rx_count++;
			if (rx_exp_q.size() == 0) begin
				errors++;
				$display("receiver reported an unexpected result at cycle %0d", cyc);
			end else begin
				check_rx_result("rx result", rx_exp_q.pop_front(), rx_result);
			end
		end
	end

	initial begin : stimulus
		uart_byte_t b;
		int         gap;
		void'($urandom(80));
		reset_n  = 1'b0;
		tx_cmd   = '0;
		loopback = 1'b0;
		ser_line = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		reset_n = 1'b1;
		compare_level("reset tx_pin", 1'b1, tx_pin);
		compare_level("reset tx_busy", 1'b0, tx_busy);
		compare_level("reset tx_done", 1'b0, tx_done);
		wait_cycles(20); // the rx monitor flags any result on the idle line.

		// Strobes keep coming while busy and must be dropped.
		loopback = 1'b1;
		while (accepted < TX_FRAMES) begin
			gap = $urandom_range(0, 12);
			wait_cycles(gap);
			b = uart_byte_t'($urandom);
			send_strobe(b);
		end
		while (tx_busy || tx_exp_q.size() != 0 || rx_exp_q.size() != 0) wait_cycles(1);
		wait_cycles(2 * CPB);

		loopback = 1'b0;
		b = uart_byte_t'($urandom);
		rx_exp_q.push_back('{valid: 1'b1, frame_error: 1'b1, data: b});
		send_serial_frame(b, 1'b0);
		wait_cycles(11 * CPB); // the line stays low and the receiver must wait.
		if (rx_exp_q.size() != 0) begin
			errors++;
			$display("frame with a low stop bit produced no result");
		end
		ser_line = 1'b1;
		wait_cycles(2 * CPB);
		b = uart_byte_t'($urandom);
		rx_exp_q.push_back('{valid: 1'b1, frame_error: 1'b0, data: b});
		send_serial_frame(b, 1'b1);
		wait_cycles(2 * CPB);

		send_glitch();
		wait_cycles(11 * CPB); // a false start would report within one frame time.
		b = uart_byte_t'($urandom);
		rx_exp_q.push_back('{valid: 1'b1, frame_error: 1'b0, data: b});
		send_serial_frame(b, 1'b1);
		wait_cycles(2 * CPB);

		if (rx_exp_q.size() != 0) begin
			errors++;
			$display("%0d expected receive results never appeared", rx_exp_q.size());
		end
		if (done_count != accepted || frames_seen != accepted) begin
			errors++;
			$display("%0d starts accepted but %0d frames and %0d done pulses seen",
				accepted, frames_seen, done_count);
		end
		if (rx_count != accepted + SER_FRAMES) begin
			errors++;
			$display("receiver gave %0d results instead of %0d", rx_count,
				accepted + SER_FRAMES);
		end
		errors += i_dut.i_sva.fail_count;
		report_counts();
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: project.f
source/uart_pkg.sv
source/baud_timer.sv
source/tx_sequencer.sv
source/tx_shifter.sv
source/rx_sequencer.sv
source/rx_shifter.sv
source/uart_core.sv
testbench/uart_core_sva.sv
testbench/uart_core_tb.sv
